// File: Bender.yml
# Shell glue block, DDR stats pipelines, FLR response and ready merge
package:
  name: shell_glue

sources:
  # RTL in compile order
  - logic/shell_glue_pkg.sv
  - logic/stat_pipe.sv
  - logic/shell_ctrl.sv
  - logic/shell_glue_top.sv

  # Testbench, top module tb_shell_glue
  - target: test
    files:
      - tb/tb_shell_glue.sv

// File: logic/shell_ctrl.sv
// Shell control, FLR done handshake, DDR ready merge and delayed controller reset
`timescale 1ns/100ps

module shell_ctrl
   import shell_glue_pkg::*;
(
   input  logic                  clk_main_a0,
   input  logic                  sync_rst_n,

   // Function-level reset from host
   input  logic                  flr_assert,
   output logic                  flr_done,

   // DDR ready flags
   input  logic [num_ddr_ch-1:0] ddr_ready_abd,  // From controllers, order A, B, D
   input  logic                  ddr_ready_c,    // From shell
   output logic [num_ready-1:0]  ddr_ready,      // Merged, order A, B, C, D

   // Delayed reset toward controller side
   output logic                  ctrl_rst_n
);

   // ---------------------------------------------------------
   // FLR response
   // ---------------------------------------------------------

   logic flr_assert_q;  // Sampled host request

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         // One-cycle pulse, rearms every other cycle while request held
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   // ---------------------------------------------------------
   // Ready merge
   // ---------------------------------------------------------

   logic ddr_ready_c_q;  // C flag is registered once, the rest are not

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ddr_ready_c_q <= 1'b0;  // C reads not ready until sampled
      end
      else
      begin
         ddr_ready_c_q <= ddr_ready_c;
      end
   end

   // Place flags in channel order, A/B/D pass straight through
   always_comb
   begin
      ddr_ready            = '0;
      ddr_ready[rdy_idx_a] = ddr_ready_abd[abd_idx_a];
      ddr_ready[rdy_idx_b] = ddr_ready_abd[abd_idx_b];
      ddr_ready[rdy_idx_c] = ddr_ready_c_q;
      ddr_ready[rdy_idx_d] = ddr_ready_abd[abd_idx_d];
   end

   // ---------------------------------------------------------
   // Controller reset delay
   // ---------------------------------------------------------

   // Plain shift chain, so both edges of reset arrive late by the same count
   logic [ctrl_rst_stages-1:0] rst_dly_q;

   always_ff @(posedge clk_main_a0)
   begin
      rst_dly_q <= {rst_dly_q[ctrl_rst_stages-2:0], sync_rst_n};
   end

   assign ctrl_rst_n = rst_dly_q[ctrl_rst_stages-1];  // Oldest sample

   // ---------------------------------------------------------
   // Checks
   // ---------------------------------------------------------

   // Done is a pulse, never held
   a_flr_done_pulse : assert property (
      @(posedge clk_main_a0) disable iff (!sync_rst_n)
      flr_done |=> !flr_done
   )
   else $error("flr_done high on two consecutive cycles");

   // A rise must trace back to the host request through the sample flop
   a_flr_done_cause : assert property (
      @(posedge clk_main_a0) disable iff (!sync_rst_n)
      $rose(flr_done) |-> $past(flr_assert, 2)
   )
   else $error("flr_done rose without flr_assert from the host");

endmodule

// File: logic/shell_glue_pkg.sv
// Shell glue constants, channel bit positions and DDR stats bus structs
package shell_glue_pkg;

   // ---------------------------------------------------------
   // Channel and pipeline sizing
   // ---------------------------------------------------------
   localparam int num_ddr_ch       = 3;  // Stats channels A, B, D
   localparam int stat_pipe_stages = 8;  // Register stages per stats direction
   localparam int ctrl_rst_stages  = 4;  // Controller reset delay in cycles
   localparam int num_ready        = 4;  // Merged ready flags A, B, C, D

   // ---------------------------------------------------------
   // Stats bus field widths
   // ---------------------------------------------------------
   localparam int stat_addr_w = 8;   // Stats register address
   localparam int stat_data_w = 32;  // Read and write data
   localparam int stat_int_w  = 8;   // Interrupt bits from controller

   // Bit positions in the ready flags coming from the A/B/D controllers
   localparam int abd_idx_a = 0;
   localparam int abd_idx_b = 1;
   localparam int abd_idx_d = 2;

   // Bit positions in the merged ready vector
   localparam int rdy_idx_a = 0;
   localparam int rdy_idx_b = 1;
   localparam int rdy_idx_c = 2;  // C comes from the shell side
   localparam int rdy_idx_d = 3;

   // ---------------------------------------------------------
   // Stats structs
   // ---------------------------------------------------------

   // Shell to controller, one per channel per cycle
   typedef struct packed {
      logic                   wr;     // Write strobe
      logic                   rd;     // Read strobe
      logic [stat_addr_w-1:0] addr;   // Register address
      logic [stat_data_w-1:0] wdata;  // Write data
   } stat_req_t;

   // Controller to shell
   typedef struct packed {
      logic                   ack;    // Access done
      logic [stat_int_w-1:0]  intr;   // Interrupt bits
      logic [stat_data_w-1:0] rdata;  // Read data
   } stat_rsp_t;

   // Flat widths, 42 and 41 bits
   localparam int stat_req_w = $bits(stat_req_t);
   localparam int stat_rsp_w = $bits(stat_rsp_t);

endpackage

// File: logic/shell_glue_top.sv
// Shell glue top, DDR stats pipelines in both directions plus shell control
`timescale 1ns/100ps

module shell_glue_top
   import shell_glue_pkg::*;
(
   input  logic                             clk_main_a0,
   input  logic                             sync_rst_n,   // Already synchronized

   // ---------------------------------------------------------
   // DDR stats, channels A, B, D
   // ---------------------------------------------------------
   input  stat_req_t [num_ddr_ch-1:0]       stat_req_in,  // From shell
   output stat_req_t [num_ddr_ch-1:0]       stat_req_out, // Toward controllers
   input  stat_rsp_t [num_ddr_ch-1:0]       stat_rsp_in,  // From controllers
   output stat_rsp_t [num_ddr_ch-1:0]       stat_rsp_out, // Toward shell

   // ---------------------------------------------------------
   // Function-level reset
   // ---------------------------------------------------------
   input  logic                             flr_assert,
   output logic                             flr_done,

   // ---------------------------------------------------------
   // DDR ready and controller reset
   // ---------------------------------------------------------
   input  logic [num_ddr_ch-1:0]            ddr_ready_abd,
   input  logic                             ddr_ready_c,
   output logic [num_ready-1:0]             ddr_ready,
   output logic                             ctrl_rst_n
);

   // ---------------------------------------------------------
   // Flat views of the stats arrays
   // ---------------------------------------------------------

   // All channels side by side, channel 0 in the low bits
   logic [num_ddr_ch*stat_req_w-1:0] req_bus_in;
   logic [num_ddr_ch*stat_req_w-1:0] req_bus_out;
   logic [num_ddr_ch*stat_rsp_w-1:0] rsp_bus_in;
   logic [num_ddr_ch*stat_rsp_w-1:0] rsp_bus_out;

   assign req_bus_in   = stat_req_in;
   assign stat_req_out = req_bus_out;
   assign rsp_bus_in   = stat_rsp_in;
   assign stat_rsp_out = rsp_bus_out;

   // ---------------------------------------------------------
   // Stats request pipeline, shell to controllers
   // ---------------------------------------------------------

   stat_pipe #(
      .WIDTH  (num_ddr_ch * stat_req_w),  // 3 x 42
      .STAGES (stat_pipe_stages)
   ) u_stat_req_pipe (
      .clk_main_a0 (clk_main_a0),
      .sync_rst_n  (sync_rst_n),
      .in_bus      (req_bus_in),
      .out_bus     (req_bus_out)
   );

   // ---------------------------------------------------------
   // Stats response pipeline, controllers to shell
   // ---------------------------------------------------------

   stat_pipe #(
      .WIDTH  (num_ddr_ch * stat_rsp_w),  // 3 x 41
      .STAGES (stat_pipe_stages)          // Same depth as requests
   ) u_stat_rsp_pipe (
      .clk_main_a0 (clk_main_a0),
      .sync_rst_n  (sync_rst_n),
      .in_bus      (rsp_bus_in),
      .out_bus     (rsp_bus_out)
   );

   // ---------------------------------------------------------
   // FLR, ready merge and controller reset
   // ---------------------------------------------------------

   shell_ctrl u_shell_ctrl (
      .clk_main_a0   (clk_main_a0),
      .sync_rst_n    (sync_rst_n),
      .flr_assert    (flr_assert),
      .flr_done      (flr_done),
      .ddr_ready_abd (ddr_ready_abd),
      .ddr_ready_c   (ddr_ready_c),
      .ddr_ready     (ddr_ready),
      .ctrl_rst_n    (ctrl_rst_n)
   );

endmodule

// File: logic/stat_pipe.sv
// Stats pipeline, a fixed-depth chain of resettable registers
`timescale 1ns/100ps

module stat_pipe #(
   parameter int WIDTH  = 42,  // Bus width
   parameter int STAGES = 8    // Register count, latency in cycles
) (
   input  logic             clk_main_a0,
   input  logic             sync_rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   // ---------------------------------------------------------
   // Register chain
   // ---------------------------------------------------------

   logic [WIDTH-1:0] pipe_q [STAGES];  // Stage 0 nearest the input

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         // All stages clear so no stale strobe leaves after reset
         for (int i = 0; i < STAGES; i++)
         begin
            pipe_q[i] <= '0;
         end
      end
      else
      begin
         pipe_q[0] <= in_bus;  // Capture
         for (int i = 1; i < STAGES; i++)
         begin
            pipe_q[i] <= pipe_q[i-1];  // Shift one stage on
         end
      end
   end

   assign out_bus = pipe_q[STAGES-1];  // Last stage

   // ---------------------------------------------------------
   // Fill tracking for the latency check
   // ---------------------------------------------------------

   // Counts edges since reset release, stops at STAGES
   logic [$clog2(STAGES+1)-1:0] fill_cnt;

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         fill_cnt <= '0;
      end
      else if (fill_cnt != STAGES[$clog2(STAGES+1)-1:0])
      begin
         fill_cnt <= fill_cnt + 1'b1;
      end
   end

   // Once the chain holds only post-reset data, output is input STAGES edges back
   a_pipe_latency : assert property (
      @(posedge clk_main_a0) disable iff (!sync_rst_n)
      (fill_cnt == STAGES[$clog2(STAGES+1)-1:0]) |-> (out_bus == $past(in_bus, STAGES))
   )
   else $error("stat_pipe output does not match input from %0d cycles back", STAGES);

endmodule

// File: sources.f
logic/shell_glue_pkg.sv
logic/stat_pipe.sv
logic/shell_ctrl.sv
logic/shell_glue_top.sv
tb/tb_shell_glue.sv

// File: tb/tb_shell_glue.sv
// Directed testbench for the shell glue, stats pipelines, FLR response, ready merge and reset delay
`timescale 1ns/100ps

module tb_shell_glue
   import shell_glue_pkg::*;
();

   // ------------------------------------------------------------
   // Run lengths and timing
   // ------------------------------------------------------------
   localparam int clk_period   = 4;   // ns
   localparam int rst_cycles   = 4;   // Reset held low at start
   localparam int stream_len   = 16;  // Back-to-back stats items per direction
   localparam int flr_hold     = 7;   // Odd, so the request drops while done is low
   localparam int flr_tail     = 5;   // Cycles watched after the drop
   localparam int ready_len    = 12;  // Random ready patterns
   localparam int fill_len     = 10;  // Cycles to load the pipes before the pulse
   localparam int pulse_window = 8;   // Cycles watched around the reset pulse

   localparam int total_cycles = rst_cycles
                               + 2 * (stream_len + stat_pipe_stages)
                               + (1 + flr_hold + flr_tail)
                               + (ready_len + 1)
                               + (fill_len + 1 + pulse_window);
   localparam int watchdog_ns  = 2 * total_cycles * clk_period;

   // All channels of one cycle together
   typedef stat_req_t [num_ddr_ch-1:0] req_vec_t;
   typedef stat_rsp_t [num_ddr_ch-1:0] rsp_vec_t;

   // ------------------------------------------------------------
   // DUT signals
   // ------------------------------------------------------------
   logic                  clk_main_a0;
   logic                  sync_rst_n;
   req_vec_t              stat_req_in;
   req_vec_t              stat_req_out;
   rsp_vec_t              stat_rsp_in;
   rsp_vec_t              stat_rsp_out;
   logic                  flr_assert;
   logic                  flr_done;
   logic [num_ddr_ch-1:0] ddr_ready_abd;
   logic                  ddr_ready_c;
   logic [num_ready-1:0]  ddr_ready;
   logic                  ctrl_rst_n;

   logic [31:0] lfsr_q = 32'he50c;  // Random source state

   shell_glue_top DUT (
      .clk_main_a0   (clk_main_a0),
      .sync_rst_n    (sync_rst_n),
      .stat_req_in   (stat_req_in),
      .stat_req_out  (stat_req_out),
      .stat_rsp_in   (stat_rsp_in),
      .stat_rsp_out  (stat_rsp_out),
      .flr_assert    (flr_assert),
      .flr_done      (flr_done),
      .ddr_ready_abd (ddr_ready_abd),
      .ddr_ready_c   (ddr_ready_c),
      .ddr_ready     (ddr_ready),
      .ctrl_rst_n    (ctrl_rst_n)
   );

   // Free-running clock
   initial
   begin
      clk_main_a0 = 1'b0;
      forever #(clk_period / 2) clk_main_a0 = ~clk_main_a0;
   end

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------

   // Galois LFSR, one step per bit returned, first bit ends up in the MSB
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      logic        lsb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lsb    = lfsr_q[0];
         lfsr_q = lfsr_q >> 1;
         if (lsb)
         begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;  // Taps 32, 22, 2, 1
         end
         v = {v[62:0], lsb};
      end
      return v;
   endfunction

   // Rising edge, then the drive offset
   task automatic wait_cycle();
      @(posedge clk_main_a0);
      #1;
   endtask

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (actual !== expected)
      begin
         $display("mismatch %s expected %0h actual %0h", name, expected, actual);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------

   // Everything quiet straight after reset release
   task automatic test_reset_state();
      // Before the first edge, so only reset values are visible
      check_value("flr_done", 1'b0, flr_done);
      check_value("ddr_ready[2]", 1'b0, ddr_ready[2]);  // C register cleared
      for (int ch = 0; ch < num_ddr_ch; ch++)
      begin
         check_value($sformatf("stat_req_out[%0d].wr", ch), 1'b0, stat_req_out[ch].wr);
         check_value($sformatf("stat_req_out[%0d].rd", ch), 1'b0, stat_req_out[ch].rd);
         check_value($sformatf("stat_rsp_out[%0d].ack", ch), 1'b0, stat_rsp_out[ch].ack);
      end
   endtask

   // Each request shows on the same channel 8 cycles after it was driven
   task automatic test_stat_requests();
      req_vec_t    exp_q[$];
      req_vec_t    vec;
      req_vec_t    exp;
      logic [63:0] r;
      for (int c = 0; c < stream_len + stat_pipe_stages; c++)
      begin
         wait_cycle();
         if (c >= stat_pipe_stages)  // Oldest item due now
         begin
            exp = exp_q.pop_front();
            for (int ch = 0; ch < num_ddr_ch; ch++)
            begin
               check_value($sformatf("stat_req_out[%0d]", ch), exp[ch], stat_req_out[ch]);
            end
         end
         if (c < stream_len)
         begin
            for (int ch = 0; ch < num_ddr_ch; ch++)
            begin
               r       = rand_bits(stat_req_w);
               vec[ch] = r[stat_req_w-1:0];
            end
            stat_req_in = vec;
            exp_q.push_back(vec);
         end
         else
         begin
            stat_req_in = '0;  // Idle while the tail drains
         end
      end
   endtask

   // Same for the response direction
   task automatic test_stat_responses();
      rsp_vec_t    exp_q[$];
      rsp_vec_t    vec;
      rsp_vec_t    exp;
      logic [63:0] r;
      for (int c = 0; c < stream_len + stat_pipe_stages; c++)
      begin
         wait_cycle();
         if (c >= stat_pipe_stages)
         begin
            exp = exp_q.pop_front();
            for (int ch = 0; ch < num_ddr_ch; ch++)
            begin
               check_value($sformatf("stat_rsp_out[%0d]", ch), exp[ch], stat_rsp_out[ch]);
            end
         end
         if (c < stream_len)
         begin
            for (int ch = 0; ch < num_ddr_ch; ch++)
            begin
               r       = rand_bits(stat_rsp_w);
               vec[ch] = r[stat_rsp_w-1:0];
            end
            stat_rsp_in = vec;
            exp_q.push_back(vec);
         end
         else
         begin
            stat_rsp_in = '0;
         end
      end
   endtask

   // Held request gives done on every second cycle, starting at cycle 2
   task automatic test_flr();
      logic exp;
      flr_assert = 1'b1;  // Cycle 0
      for (int c = 1; c <= flr_hold; c++)
      begin
         wait_cycle();
         exp = (c >= 2) && (c % 2 == 0);
         check_value($sformatf("flr_done cycle %0d", c), exp, flr_done);
      end
      flr_assert = 1'b0;  // Dropped while done is low
      for (int c = 1; c <= flr_tail; c++)
      begin
         wait_cycle();
         // Sample flop still high for one more edge
         exp = (c == 1);
         check_value($sformatf("flr_done after drop %0d", c), exp, flr_done);
      end
   endtask

   // A, B, D straight through, C one cycle late
   task automatic test_ready_merge();
      logic [num_ddr_ch-1:0] abd;
      logic                  c_now;
      logic                  c_prev;
      logic [63:0]           r;
      c_prev = ddr_ready_c;
      for (int i = 0; i < ready_len; i++)
      begin
         wait_cycle();
         r             = rand_bits(num_ddr_ch);
         abd           = r[num_ddr_ch-1:0];
         r             = rand_bits(1);
         c_now         = r[0];
         ddr_ready_abd = abd;
         ddr_ready_c   = c_now;
         #1;  // Let the merge settle
         check_value("ddr_ready[0] A", abd[0], ddr_ready[0]);
         check_value("ddr_ready[1] B", abd[1], ddr_ready[1]);
         check_value("ddr_ready[2] C", c_prev, ddr_ready[2]);
         check_value("ddr_ready[3] D", abd[2], ddr_ready[3]);
         c_prev = c_now;
      end
      wait_cycle();
      check_value("ddr_ready[2] C", c_prev, ddr_ready[2]);  // Last C value
   endtask

   // Short reset pulse, controller reset follows 4 cycles late
   task automatic test_ctrl_reset();
      req_vec_t    req;
      rsp_vec_t    rsp;
      logic [63:0] r;
      logic        exp;
      // Load the pipes with traffic first
      for (int i = 0; i < fill_len; i++)
      begin
         wait_cycle();
         for (int ch = 0; ch < num_ddr_ch; ch++)
         begin
            r       = rand_bits(stat_req_w);
            req[ch] = r[stat_req_w-1:0];
            r       = rand_bits(stat_rsp_w);
            rsp[ch] = r[stat_rsp_w-1:0];
         end
         stat_req_in = req;
         stat_rsp_in = rsp;
      end
      wait_cycle();
      check_value("ctrl_rst_n before pulse", 1'b1, ctrl_rst_n);
      sync_rst_n = 1'b0;  // Cycle 0
      #1;
      check_value("stat_req_out in reset", '0, stat_req_out);  // Async clear
      check_value("stat_rsp_out in reset", '0, stat_rsp_out);
      for (int c = 1; c <= pulse_window; c++)
      begin
         wait_cycle();
         exp = !((c >= ctrl_rst_stages) && (c < ctrl_rst_stages + 2));
         check_value($sformatf("ctrl_rst_n cycle %0d", c), exp, ctrl_rst_n);
         // Inputs still busy, but nothing has reached the outputs yet
         check_value($sformatf("stat_req_out cycle %0d", c), '0, stat_req_out);
         check_value($sformatf("stat_rsp_out cycle %0d", c), '0, stat_rsp_out);
         if (c == 2)
         begin
            sync_rst_n = 1'b1;  // Two cycles low
         end
      end
      stat_req_in = '0;
      stat_rsp_in = '0;
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial
   begin
      sync_rst_n    = 1'b0;
      stat_req_in   = '0;
      stat_rsp_in   = '0;
      flr_assert    = 1'b0;
      ddr_ready_abd = '0;
      ddr_ready_c   = 1'b0;
      repeat (rst_cycles) @(posedge clk_main_a0);
      #1;
      sync_rst_n = 1'b1;

      test_reset_state();
      test_stat_requests();
      test_stat_responses();
      test_flr();
      test_ready_merge();
      test_ctrl_reset();

      $display("TESTBENCH PASSED");
      $finish;
   end

   // Watchdog, twice the expected run length
   initial
   begin
      #(watchdog_ns);
      $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
      $display("TESTBENCH FAILED");
      $fatal(1);
   end

endmodule
